//--- rtl/csr_addr_pkg.sv
package csr_addr_pkg;

    // machine trap setup and handling
    localparam logic [11:0] CSR_MSTATUS       = 12'h300;
    localparam logic [11:0] CSR_MIE           = 12'h304;
    localparam logic [11:0] CSR_MTVEC         = 12'h305;
    localparam logic [11:0] CSR_MCOUNTEREN    = 12'h306;
    localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
    localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
    localparam logic [11:0] CSR_MEPC          = 12'h341;
    localparam logic [11:0] CSR_MCAUSE        = 12'h342;
    localparam logic [11:0] CSR_MTVAL         = 12'h343;
    localparam logic [11:0] CSR_MIP           = 12'h344;

    // machine counters and their user aliases
    localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH       = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH     = 12'hB82;
    localparam logic [11:0] CSR_CYCLE         = 12'hC00;
    localparam logic [11:0] CSR_INSTRET       = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH        = 12'hC80;
    localparam logic [11:0] CSR_INSTRETH      = 12'hC82;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int MSTATUS_MPP_HI   = 12;
    // mip uses the same positions as mie
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIE_MEIE_BIT     = 11;
    // mcounteren and mcountinhibit
    localparam int COUNTER_CY_BIT   = 0;
    localparam int COUNTER_IR_BIT   = 2;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mcounteren;
        logic mcountinhibit;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mip;
        logic mcycle;
        logic mcycleh;
        logic minstret;
        logic minstreth;
        logic cycle;
        logic cycleh;
        logic instret;
        logic instreth;
    } csr_sel_t;

endpackage

//--- rtl/trap_pkg.sv
package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_INSTR_FAULT      = 5'd1,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_LOAD_FAULT       = 5'd5,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_STORE_FAULT      = 5'd7,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_M          = 5'd11
    } exception_e;

    typedef enum logic [4:0] {
        INT_M_SOFT  = 5'd3,
        INT_M_TIMER = 5'd7,
        INT_M_EXT   = 5'd11
    } interrupt_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_e;

    typedef struct packed {
        logic        en;
        logic        read;
        logic        write;
        logic        mret;
        logic [11:0] id;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic        exception_valid;
        exception_e  exception_cause;
        logic [31:0] exception_value;
        logic        interrupt_valid;
        interrupt_e  interrupt_cause;
    } trap_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic  mie;
        logic  mpie;
        priv_e mpp;
    } status_t;

endpackage

//--- rtl/csr_access_check.sv
`timescale 1ns/100ps

module csr_access_check
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  csr_req_t   csr_req,
    input  trap_req_t  trap_req,
    input  priv_e      priv,
    input  logic [1:0] mcounteren,
    output csr_sel_t   sel,
    output logic       write_en,
    output logic       mret_take,
    output logic       illegal
);

    logic m_read_ok;
    logic m_write_ok;
    logic u_read_ok;
    logic read_only;

    always_comb begin
        sel               = '0;
        sel.mstatus       = (csr_req.id == CSR_MSTATUS);
        sel.mie           = (csr_req.id == CSR_MIE);
        sel.mtvec         = (csr_req.id == CSR_MTVEC);
        sel.mcounteren    = (csr_req.id == CSR_MCOUNTEREN);
        sel.mcountinhibit = (csr_req.id == CSR_MCOUNTINHIBIT);
        sel.mscratch      = (csr_req.id == CSR_MSCRATCH);
        sel.mepc          = (csr_req.id == CSR_MEPC);
        sel.mcause        = (csr_req.id == CSR_MCAUSE);
        sel.mtval         = (csr_req.id == CSR_MTVAL);
        sel.mip           = (csr_req.id == CSR_MIP);
        sel.mcycle        = (csr_req.id == CSR_MCYCLE);
        sel.mcycleh       = (csr_req.id == CSR_MCYCLEH);
        sel.minstret      = (csr_req.id == CSR_MINSTRET);
        sel.minstreth     = (csr_req.id == CSR_MINSTRETH);
        sel.cycle         = (csr_req.id == CSR_CYCLE);
        sel.cycleh        = (csr_req.id == CSR_CYCLEH);
        sel.instret       = (csr_req.id == CSR_INSTRET);
        sel.instreth      = (csr_req.id == CSR_INSTRETH);
    end

    // mip and the user aliases cannot be written
    assign read_only  = sel.mip | sel.cycle | sel.cycleh | sel.instret | sel.instreth;
    assign m_read_ok  = |sel;
    assign m_write_ok = |sel & ~read_only;
    assign u_read_ok  = ((sel.cycle | sel.cycleh) & mcounteren[0])
                      | ((sel.instret | sel.instreth) & mcounteren[1]);

    assign write_en  = csr_req.en & csr_req.write & ~trap_req.exception_valid;
    assign mret_take = csr_req.en & csr_req.mret & (priv == PRIV_M);

    always_comb begin
        illegal = 1'b0;
        if (csr_req.en) begin
            if (priv == PRIV_M) begin
                illegal = (csr_req.read & ~m_read_ok) | (csr_req.write & ~m_write_ok);
            end else begin
                illegal = (csr_req.read & ~u_read_ok) | csr_req.write | csr_req.mret;
            end
        end
    end

endmodule

//--- rtl/csr_priv_fsm.sv
`timescale 1ns/100ps

module csr_priv_fsm
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  trap_req_t   trap_req,
    input  logic        mret_take,
    input  csr_sel_t    sel,
    input  logic        write_en,
    input  logic [31:0] wdata,
    input  logic [29:0] mtvec_base,
    input  mtvec_mode_e mtvec_mode,
    input  logic [31:0] mepc,
    output priv_e       priv,
    output status_t     status,
    output redirect_t   redirect
);

    logic    trap;
    logic    mpp_ok;
    priv_e   priv_next;
    status_t status_next;
    priv_e   wr_mpp;
    logic [4:0] vec_off;

    assign trap   = trap_req.exception_valid | trap_req.interrupt_valid;
    assign wr_mpp = priv_e'(wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
    assign mpp_ok = (wr_mpp == PRIV_M) || (wr_mpp == PRIV_U);

    always_comb begin
        priv_next   = priv;
        status_next = status;
        if (trap) begin
            priv_next        = PRIV_M;
            status_next.mie  = 1'b0;
            status_next.mpie = status.mie;
            status_next.mpp  = priv;
        end else if (mret_take) begin
            priv_next        = status.mpp;
            status_next.mie  = status.mpie;
            status_next.mpie = 1'b1;
            status_next.mpp  = PRIV_U;
        end else if (write_en && sel.mstatus) begin
            status_next.mie  = wdata[MSTATUS_MIE_BIT];
            status_next.mpie = wdata[MSTATUS_MPIE_BIT];
            if (mpp_ok) begin
                status_next.mpp = wr_mpp;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv   <= PRIV_M;
            status <= '{mie: 1'b0, mpie: 1'b1, mpp: PRIV_U};
        end else begin
            priv   <= priv_next;
            status <= status_next;
        end
    end

    // exceptions land on the base even in vectored mode
    assign vec_off = trap_req.interrupt_valid ? trap_req.interrupt_cause : 5'd0;

    always_comb begin
        redirect = '0;
        if (trap) begin
            redirect.valid = 1'b1;
            if (mtvec_mode == MTVEC_VECTORED) begin
                redirect.pc = {mtvec_base + {25'd0, vec_off}, 2'b00};
            end else begin
                redirect.pc = {mtvec_base, 2'b00};
            end
        end else if (mret_take) begin
            redirect.valid = 1'b1;
            redirect.pc    = mepc;
        end
    end

    // mret only arrives already qualified by machine mode
    a_mret_in_m: assert property (@(posedge clk) disable iff (!rst_n)
        mret_take |-> (priv == PRIV_M));

    // the regfile never hands over a reserved mtvec mode
    a_trap_mode: assert property (@(posedge clk) disable iff (!rst_n)
        trap |-> (mtvec_mode == MTVEC_DIRECT || mtvec_mode == MTVEC_VECTORED));

endmodule

//--- rtl/csr_counters.sv
`timescale 1ns/100ps

module csr_counters
    import csr_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  csr_sel_t    sel,
    input  logic        write_en,
    input  logic [31:0] wdata,
    input  logic        instr_done,
    input  logic        exception_valid,
    input  logic [1:0]  inhibit,
    output logic [63:0] mcycle,
    output logic [63:0] minstret
);

    logic cycle_inc;
    logic instret_inc;

    // a written half wins, the other half keeps counting
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] nxt;
        nxt = inc ? cur + 64'd1 : cur;
        if (wr_lo) begin
            nxt[31:0] = data;
        end else if (wr_hi) begin
            nxt[63:32] = data;
        end
        return nxt;
    endfunction

    assign cycle_inc   = ~inhibit[0];
    assign instret_inc = ~inhibit[1] & instr_done & ~exception_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle   <= 64'd0;
            minstret <= 64'd0;
        end else begin
            mcycle   <= count_next(mcycle, cycle_inc, write_en & sel.mcycle,
                                   write_en & sel.mcycleh, wdata);
            minstret <= count_next(minstret, instret_inc, write_en & sel.minstret,
                                   write_en & sel.minstreth, wdata);
        end
    end

endmodule

//--- rtl/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  csr_sel_t    sel,
    input  logic        write_en,
    input  logic [31:0] wdata,
    input  trap_req_t   trap_req,
    input  logic [31:0] pc,
    input  priv_e       priv,
    input  status_t     status,
    input  logic [63:0] mcycle,
    input  logic [63:0] minstret,
    input  logic        int_m_ext,
    input  logic        mtimer_int,
    output logic [29:0] mtvec_base,
    output mtvec_mode_e mtvec_mode,
    output logic [31:0] mepc,
    output logic [1:0]  mcounteren,
    output logic [1:0]  inhibit,
    output logic        cfg_meie,
    output logic        cfg_mtie,
    output logic [31:0] rdata
);

    logic        trap;
    logic        mode_ok;
    logic        user_visible;
    logic [31:0] mscratch;
    logic [29:0] mepc_base;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mux_data;

    assign trap    = trap_req.exception_valid | trap_req.interrupt_valid;
    assign mode_ok = (wdata[1:0] == MTVEC_DIRECT) || (wdata[1:0] == MTVEC_VECTORED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_base <= 30'd0;
            mtvec_mode <= MTVEC_DIRECT;
            cfg_meie   <= 1'b0;
            cfg_mtie   <= 1'b0;
            mcounteren <= 2'b00;
            inhibit    <= 2'b00;
            mscratch   <= 32'd0;
            mepc_base  <= 30'd0;
            mcause     <= 32'd0;
            mtval      <= 32'd0;
        end else begin
            if (write_en && sel.mtvec) begin
                mtvec_base <= wdata[31:2];
                if (mode_ok) begin
                    mtvec_mode <= mtvec_mode_e'(wdata[1:0]);
                end
            end
            if (write_en && sel.mie) begin
                cfg_meie <= wdata[MIE_MEIE_BIT];
                cfg_mtie <= wdata[MIE_MTIE_BIT];
            end
            if (write_en && sel.mcounteren) begin
                mcounteren <= {wdata[COUNTER_IR_BIT], wdata[COUNTER_CY_BIT]};
            end
            if (write_en && sel.mcountinhibit) begin
                inhibit <= {wdata[COUNTER_IR_BIT], wdata[COUNTER_CY_BIT]};
            end
            if (write_en && sel.mscratch) begin
                mscratch <= wdata;
            end
            // trap capture beats a same-cycle write
            if (trap) begin
                mepc_base <= pc[31:2];
                if (trap_req.interrupt_valid) begin
                    mcause <= {1'b1, 26'd0, trap_req.interrupt_cause};
                    mtval  <= 32'd0;
                end else begin
                    mcause <= {27'd0, trap_req.exception_cause};
                    mtval  <= trap_req.exception_value;
                end
            end else begin
                if (write_en && sel.mepc) mepc_base <= wdata[31:2];
                if (write_en && sel.mcause) mcause <= wdata;
                if (write_en && sel.mtval) mtval <= wdata;
            end
        end
    end

    assign mepc = {mepc_base, 2'b00};

    always_comb begin
        mux_data = 32'd0;
        unique case (1'b1)
            sel.mstatus: begin
                mux_data[MSTATUS_MIE_BIT]                = status.mie;
                mux_data[MSTATUS_MPIE_BIT]               = status.mpie;
                mux_data[MSTATUS_MPP_HI:MSTATUS_MPP_LO]  = status.mpp;
            end
            sel.mie: begin
                mux_data[MIE_MEIE_BIT] = cfg_meie;
                mux_data[MIE_MTIE_BIT] = cfg_mtie;
            end
            sel.mip: begin
                mux_data[MIE_MEIE_BIT] = int_m_ext;
                mux_data[MIE_MTIE_BIT] = mtimer_int;
            end
            sel.mtvec:                  mux_data = {mtvec_base, mtvec_mode};
            sel.mcounteren: begin
                mux_data[COUNTER_CY_BIT] = mcounteren[0];
                mux_data[COUNTER_IR_BIT] = mcounteren[1];
            end
            sel.mcountinhibit: begin
                mux_data[COUNTER_CY_BIT] = inhibit[0];
                mux_data[COUNTER_IR_BIT] = inhibit[1];
            end
            sel.mscratch:               mux_data = mscratch;
            sel.mepc:                   mux_data = mepc;
            sel.mcause:                 mux_data = mcause;
            sel.mtval:                  mux_data = mtval;
            sel.mcycle, sel.cycle:      mux_data = mcycle[31:0];
            sel.mcycleh, sel.cycleh:    mux_data = mcycle[63:32];
            sel.minstret, sel.instret:  mux_data = minstret[31:0];
            sel.minstreth, sel.instreth: mux_data = minstret[63:32];
            default:                    mux_data = 32'd0;
        endcase
    end

    // user mode only sees the counter aliases
    assign user_visible = sel.cycle | sel.cycleh | sel.instret | sel.instreth;
    assign rdata = (priv == PRIV_M || user_visible) ? mux_data : 32'd0;

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/100ps

module csr_top
    import csr_addr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  csr_req_t    csr_req,
    input  trap_req_t   trap_req,
    input  logic [31:0] pc,
    input  logic        instr_done,
    input  logic        int_m_ext,
    input  logic        mtimer_int,
    output logic [31:0] csr_rdata,
    output redirect_t   redirect,
    output logic        illegal,
    output priv_e       priv,
    output logic        cfg_mie,
    output logic        cfg_meie,
    output logic        cfg_mtie
);

    csr_sel_t    sel;
    logic        write_en;
    logic        mret_take;
    status_t     status;
    logic [29:0] mtvec_base;
    mtvec_mode_e mtvec_mode;
    logic [31:0] mepc;
    logic [1:0]  mcounteren;
    logic [1:0]  inhibit;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    csr_access_check u_access_check (
        .csr_req    (csr_req),
        .trap_req   (trap_req),
        .priv       (priv),
        .mcounteren (mcounteren),
        .sel        (sel),
        .write_en   (write_en),
        .mret_take  (mret_take),
        .illegal    (illegal)
    );

    csr_priv_fsm u_priv_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .trap_req   (trap_req),
        .mret_take  (mret_take),
        .sel        (sel),
        .write_en   (write_en),
        .wdata      (csr_req.wdata),
        .mtvec_base (mtvec_base),
        .mtvec_mode (mtvec_mode),
        .mepc       (mepc),
        .priv       (priv),
        .status     (status),
        .redirect   (redirect)
    );

    csr_counters u_counters (
        .clk             (clk),
        .rst_n           (rst_n),
        .sel             (sel),
        .write_en        (write_en),
        .wdata           (csr_req.wdata),
        .instr_done      (instr_done),
        .exception_valid (trap_req.exception_valid),
        .inhibit         (inhibit),
        .mcycle          (mcycle),
        .minstret        (minstret)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .write_en   (write_en),
        .wdata      (csr_req.wdata),
        .trap_req   (trap_req),
        .pc         (pc),
        .priv       (priv),
        .status     (status),
        .mcycle     (mcycle),
        .minstret   (minstret),
        .int_m_ext  (int_m_ext),
        .mtimer_int (mtimer_int),
        .mtvec_base (mtvec_base),
        .mtvec_mode (mtvec_mode),
        .mepc       (mepc),
        .mcounteren (mcounteren),
        .inhibit    (inhibit),
        .cfg_meie   (cfg_meie),
        .cfg_mtie   (cfg_mtie),
        .rdata      (csr_rdata)
    );

    assign cfg_mie = status.mie;

endmodule

//--- dv/csr_checker.sv
`timescale 1ns/100ps

module csr_checker
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        active,
    input  string       step_name,
    input  logic        rd_chk,
    input  logic [31:0] exp_rdata,
    input  logic        exp_illegal,
    input  redirect_t   exp_redirect,
    input  priv_e       exp_priv,
    input  logic        exp_mie,
    input  logic        exp_meie,
    input  logic        exp_mtie,
    input  logic [31:0] csr_rdata,
    input  redirect_t   redirect,
    input  logic        illegal,
    input  priv_e       priv,
    input  logic        cfg_mie,
    input  logic        cfg_meie,
    input  logic        cfg_mtie,
    output int          error_count,
    output int          check_count
);

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s %s: expected 0x%08h actual 0x%08h", step_name, what, exp, act);
        end
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (active) begin
            if (rd_chk) begin
                compare("rdata", exp_rdata, csr_rdata);
            end
            compare("illegal", {31'd0, exp_illegal}, {31'd0, illegal});
            compare("redirect.valid", {31'd0, exp_redirect.valid}, {31'd0, redirect.valid});
            if (exp_redirect.valid) begin
                compare("redirect.pc", exp_redirect.pc, redirect.pc);
            end
            compare("priv", {30'd0, exp_priv}, {30'd0, priv});
            compare("cfg_mie", {31'd0, exp_mie}, {31'd0, cfg_mie});
            compare("cfg_meie", {31'd0, exp_meie}, {31'd0, cfg_meie});
            compare("cfg_mtie", {31'd0, exp_mtie}, {31'd0, cfg_mtie});
        end
    end

endmodule

//--- dv/tb_csr.sv
`timescale 1ns/100ps

module tb_csr
    import csr_addr_pkg::*;
    import trap_pkg::*;
();

    typedef struct packed {
        csr_req_t    req;
        trap_req_t   trap;
        logic [31:0] pc;
        logic        instr_done;
        logic        ext_int;
        logic        timer_int;
        logic        rd_chk;
        logic [31:0] rdata;
        logic        illegal;
        redirect_t   redirect;
        priv_e       priv;
        logic        mie;
        logic        meie;
        logic        mtie;
    } step_t;

    logic        clk;
    logic        rst_n;
    csr_req_t    csr_req;
    trap_req_t   trap_req;
    logic [31:0] pc;
    logic        instr_done;
    logic        int_m_ext;
    logic        mtimer_int;
    logic [31:0] csr_rdata;
    redirect_t   redirect;
    logic        illegal;
    priv_e       priv;
    logic        cfg_mie;
    logic        cfg_meie;
    logic        cfg_mtie;

    step_t       steps[$];
    string       names[$];
    step_t       v;
    step_t       cur;
    string       cur_name;
    logic        active;
    int          error_count;
    int          check_count;
    int          wait_cnt;
    integer      seed;

    // expected privilege and mstatus state
    priv_e       m_priv;
    logic        m_mie;
    logic        m_mpie;
    priv_e       m_mpp;
    logic        m_meie;
    logic        m_mtie;
    logic        pin_ext;
    logic        pin_timer;
    logic        drive_done;

    logic [31:0] r_scr;
    logic [31:0] r_epc;
    logic [31:0] r_cause;
    logic [31:0] r_tval;
    logic [31:0] r_val;
    logic [31:0] r_epc2;
    logic [31:0] r_ret;
    logic [31:0] r_cyc;
    logic [31:0] r_cyc2;

    csr_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_req    (csr_req),
        .trap_req   (trap_req),
        .pc         (pc),
        .instr_done (instr_done),
        .int_m_ext  (int_m_ext),
        .mtimer_int (mtimer_int),
        .csr_rdata  (csr_rdata),
        .redirect   (redirect),
        .illegal    (illegal),
        .priv       (priv),
        .cfg_mie    (cfg_mie),
        .cfg_meie   (cfg_meie),
        .cfg_mtie   (cfg_mtie)
    );

    csr_checker i_chk (
        .clk          (clk),
        .active       (active),
        .step_name    (cur_name),
        .rd_chk       (cur.rd_chk),
        .exp_rdata    (cur.rdata),
        .exp_illegal  (cur.illegal),
        .exp_redirect (cur.redirect),
        .exp_priv     (cur.priv),
        .exp_mie      (cur.mie),
        .exp_meie     (cur.meie),
        .exp_mtie     (cur.mtie),
        .csr_rdata    (csr_rdata),
        .redirect     (redirect),
        .illegal      (illegal),
        .priv         (priv),
        .cfg_mie      (cfg_mie),
        .cfg_meie     (cfg_meie),
        .cfg_mtie     (cfg_mtie),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] status_word();
        logic [31:0] w;
        w = 32'd0;
        w[MSTATUS_MIE_BIT] = m_mie;
        w[MSTATUS_MPIE_BIT] = m_mpie;
        w[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = m_mpp;
        return w;
    endfunction

    task automatic clear_step();
        v = '0;
        v.ext_int = pin_ext;
        v.timer_int = pin_timer;
        v.instr_done = drive_done;
        v.pc = 32'h0000_0100;
    endtask

    // record the step, then move the expected state past its clock edge
    task automatic push_step(input string nm);
        logic trap;
        logic [1:0] wr_mpp;
        trap = v.trap.exception_valid | v.trap.interrupt_valid;
        wr_mpp = v.req.wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO];
        v.priv = m_priv;
        v.mie = m_mie;
        v.meie = m_meie;
        v.mtie = m_mtie;
        steps.push_back(v);
        names.push_back(nm);
        if (trap) begin
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mpp = m_priv;
            m_priv = PRIV_M;
        end else if (v.req.en && v.req.mret && m_priv == PRIV_M) begin
            m_priv = m_mpp;
            m_mie = m_mpie;
            m_mpie = 1'b1;
            m_mpp = PRIV_U;
        end else if (v.req.en && v.req.write && v.req.id == CSR_MSTATUS) begin
            m_mie = v.req.wdata[MSTATUS_MIE_BIT];
            m_mpie = v.req.wdata[MSTATUS_MPIE_BIT];
            if (wr_mpp == PRIV_M || wr_mpp == PRIV_U) begin
                m_mpp = priv_e'(wr_mpp);
            end
        end
        if (v.req.en && v.req.write && !v.trap.exception_valid && v.req.id == CSR_MIE) begin
            m_meie = v.req.wdata[MIE_MEIE_BIT];
            m_mtie = v.req.wdata[MIE_MTIE_BIT];
        end
    endtask

    task automatic idle_step(input string nm);
        clear_step();
        push_step(nm);
    endtask

    task automatic csr_write(input string nm, input logic [11:0] id, input logic [31:0] wdata,
                             input logic exp_illegal);
        clear_step();
        v.req.en = 1'b1;
        v.req.write = 1'b1;
        v.req.id = id;
        v.req.wdata = wdata;
        v.illegal = exp_illegal;
        push_step(nm);
    endtask

    task automatic csr_read(input string nm, input logic [11:0] id, input logic rd_chk,
                            input logic [31:0] exp_rdata, input logic exp_illegal);
        clear_step();
        v.req.en = 1'b1;
        v.req.read = 1'b1;
        v.req.id = id;
        v.rd_chk = rd_chk;
        v.rdata = exp_rdata;
        v.illegal = exp_illegal;
        push_step(nm);
    endtask

    task automatic trap_step(input string nm, input logic exc, input exception_e ecause,
                             input logic [31:0] evalue, input logic intr,
                             input interrupt_e icause, input logic [31:0] tpc,
                             input logic [31:0] target);
        clear_step();
        v.trap.exception_valid = exc;
        v.trap.exception_cause = ecause;
        v.trap.exception_value = evalue;
        v.trap.interrupt_valid = intr;
        v.trap.interrupt_cause = icause;
        v.pc = tpc;
        v.redirect = {1'b1, target};
        push_step(nm);
    endtask

    task automatic mret_step(input string nm, input logic take, input logic [31:0] target);
        clear_step();
        v.req.en = 1'b1;
        v.req.mret = 1'b1;
        v.illegal = ~take;
        v.redirect = take ? {1'b1, target} : '0;
        push_step(nm);
    endtask

    task automatic build_table();
        r_scr = $random(seed);
        r_epc = $random(seed);
        r_cause = $random(seed);
        r_tval = $random(seed);
        r_val = $random(seed);
        r_epc2 = $random(seed);
        r_ret = $random(seed);
        r_cyc = $random(seed);
        r_cyc2 = $random(seed);

        // register write and read back
        csr_write("wr_mscratch", CSR_MSCRATCH, r_scr, 1'b0);
        csr_read("rd_mscratch", CSR_MSCRATCH, 1'b1, r_scr, 1'b0);
        csr_write("wr_mepc", CSR_MEPC, r_epc, 1'b0);
        csr_read("rd_mepc", CSR_MEPC, 1'b1, {r_epc[31:2], 2'b00}, 1'b0);
        csr_write("wr_mcause", CSR_MCAUSE, r_cause, 1'b0);
        csr_read("rd_mcause", CSR_MCAUSE, 1'b1, r_cause, 1'b0);
        csr_write("wr_mtval", CSR_MTVAL, r_tval, 1'b0);
        csr_read("rd_mtval", CSR_MTVAL, 1'b1, r_tval, 1'b0);
        csr_write("wr_mtvec", CSR_MTVEC, 32'h0000_2000, 1'b0);
        csr_write("wr_mtvec_bad", CSR_MTVEC, 32'h0000_2003, 1'b0);
        csr_read("rd_mtvec", CSR_MTVEC, 1'b1, 32'h0000_2000, 1'b0);

        // legality in machine mode
        csr_write("wr_cycle", CSR_CYCLE, r_val, 1'b1);
        csr_write("wr_mip", CSR_MIP, 32'h0000_0880, 1'b1);
        csr_read("rd_unknown", 12'h7C0, 1'b1, 32'd0, 1'b1);
        csr_read("rd_mcycle", CSR_MCYCLE, 1'b0, 32'd0, 1'b0);
        csr_read("rd_mstatus", CSR_MSTATUS, 1'b1, status_word(), 1'b0);
        csr_read("rd_mip_ext", CSR_MIP, 1'b1, 32'h0000_0800, 1'b0);
        pin_timer = 1'b1;
        csr_read("rd_mip_both", CSR_MIP, 1'b1, 32'h0000_0880, 1'b0);
        pin_ext = 1'b0;
        csr_read("rd_mip_timer", CSR_MIP, 1'b1, 32'h0000_0080, 1'b0);

        // interrupt enables, one bit at a time
        csr_write("wr_mie_ext", CSR_MIE, 32'h0000_0800, 1'b0);
        csr_write("wr_mie_both", CSR_MIE, 32'h0000_0880, 1'b0);
        csr_read("rd_mie", CSR_MIE, 1'b1, 32'h0000_0880, 1'b0);

        // trap entry, direct then vectored
        csr_write("set_mie", CSR_MSTATUS, 32'h0000_0088, 1'b0);
        trap_step("exc_direct", 1'b1, EXC_ILLEGAL_INSTR, r_val, 1'b0, INT_M_SOFT,
                  32'h0000_0444, 32'h0000_2000);
        csr_read("rd_mepc_exc", CSR_MEPC, 1'b1, 32'h0000_0444, 1'b0);
        csr_read("rd_mcause_exc", CSR_MCAUSE, 1'b1, 32'd2, 1'b0);
        csr_read("rd_mtval_exc", CSR_MTVAL, 1'b1, r_val, 1'b0);
        csr_read("rd_mstatus_exc", CSR_MSTATUS, 1'b1, status_word(), 1'b0);
        csr_write("wr_mtvec_vec", CSR_MTVEC, 32'h0000_3001, 1'b0);
        csr_read("rd_mtvec_vec", CSR_MTVEC, 1'b1, 32'h0000_3001, 1'b0);
        // interrupt with a competing mepc write
        clear_step();
        v.req.en = 1'b1;
        v.req.write = 1'b1;
        v.req.id = CSR_MEPC;
        v.req.wdata = r_epc2;
        v.trap.interrupt_valid = 1'b1;
        v.trap.interrupt_cause = INT_M_EXT;
        v.pc = 32'h0000_0888;
        v.redirect = {1'b1, 32'h0000_3000 + 32'd4 * 32'd11};
        push_step("int_vectored");
        csr_read("rd_mepc_int", CSR_MEPC, 1'b1, 32'h0000_0888, 1'b0);
        csr_read("rd_mcause_int", CSR_MCAUSE, 1'b1, 32'h8000_000B, 1'b0);
        csr_read("rd_mtval_int", CSR_MTVAL, 1'b1, 32'd0, 1'b0);

        // mret into user mode
        csr_write("set_mpp_u", CSR_MSTATUS, 32'h0000_0080, 1'b0);
        csr_write("wr_mepc_ret", CSR_MEPC, r_ret, 1'b0);
        mret_step("mret_to_u", 1'b1, {r_ret[31:2], 2'b00});
        csr_write("u_wr_mscratch", CSR_MSCRATCH, r_scr, 1'b1);
        mret_step("u_mret", 1'b0, 32'd0);

        // user counter access through mcounteren
        csr_read("u_rd_cycle_off", CSR_CYCLE, 1'b0, 32'd0, 1'b1);
        trap_step("ecall_u", 1'b1, EXC_ECALL_U, 32'd0, 1'b0, INT_M_SOFT,
                  32'h0000_0900, 32'h0000_3000);
        csr_write("wr_mcounteren", CSR_MCOUNTEREN, 32'h0000_0001, 1'b0);
        mret_step("mret_back_u", 1'b1, 32'h0000_0900);
        csr_read("u_rd_cycle_on", CSR_CYCLE, 1'b0, 32'd0, 1'b0);
        csr_read("u_rd_instret_off", CSR_INSTRET, 1'b0, 32'd0, 1'b1);
        trap_step("ecall_u_again", 1'b1, EXC_ECALL_U, 32'd0, 1'b0, INT_M_SOFT,
                  32'h0000_0904, 32'h0000_3000);

        // counters
        csr_write("wr_mcycle", CSR_MCYCLE, r_cyc, 1'b0);
        csr_read("rd_mcycle_wr", CSR_MCYCLE, 1'b1, r_cyc, 1'b0);
        csr_write("wr_inhibit_cy", CSR_MCOUNTINHIBIT, 32'h0000_0001, 1'b0);
        csr_write("wr_mcycle_held", CSR_MCYCLE, r_cyc2, 1'b0);
        csr_read("rd_mcycle_hold1", CSR_MCYCLE, 1'b1, r_cyc2, 1'b0);
        csr_read("rd_mcycle_hold2", CSR_MCYCLE, 1'b1, r_cyc2, 1'b0);
        csr_write("wr_minstret", CSR_MINSTRET, 32'd0, 1'b0);
        drive_done = 1'b1;
        idle_step("done_1");
        idle_step("done_2");
        trap_step("done_exc", 1'b1, EXC_BREAKPOINT, 32'd0, 1'b0, INT_M_SOFT,
                  32'h0000_0050, 32'h0000_3000);
        idle_step("done_3");
        drive_done = 1'b0;
        csr_read("rd_minstret", CSR_MINSTRET, 1'b1, 32'd3, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        csr_req = '0;
        trap_req = '0;
        pc = 32'd0;
        instr_done = 1'b0;
        int_m_ext = 1'b0;
        mtimer_int = 1'b0;
        active = 1'b0;
        cur = '0;
        cur_name = "";
        seed = 32'h7c29730d;
        m_priv = PRIV_M;
        m_mie = 1'b0;
        m_mpie = 1'b1;
        m_mpp = PRIV_U;
        m_meie = 1'b0;
        m_mtie = 1'b0;
        pin_ext = 1'b1;
        pin_timer = 1'b0;
        drive_done = 1'b0;
        build_table();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            $display("TESTS FAILED");
            $finish;
        end

        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            csr_req <= steps[i].req;
            trap_req <= steps[i].trap;
            pc <= steps[i].pc;
            instr_done <= steps[i].instr_done;
            int_m_ext <= steps[i].ext_int;
            mtimer_int <= steps[i].timer_int;
            cur <= steps[i];
            cur_name <= names[i];
            active <= 1'b1;
        end
        @(posedge clk);
        active <= 1'b0;
        csr_req <= '0;
        trap_req <= '0;
        instr_done <= 1'b0;
        @(negedge clk);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/csr_addr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_access_check.sv
rtl/csr_priv_fsm.sv
rtl/csr_counters.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
dv/csr_checker.sv
dv/tb_csr.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f tb.f --top-module tb_csr --Mdir obj_dir -o sim_tb_csr
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_csr)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
